/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= proc_tb
FILELIST  ?= build.f
BIN       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* build.f */
source/proc_pkg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/hazard.sv
source/proc.sv
dv/proc_props.sv
dv/proc_tb.sv

/* dv/proc_props.sv */
`timescale 1ns/1ps

module proc_props (
    input logic clk,
    input logic rst_n,
    input logic halted,
    input logic snd,
    input logic reg_wr_en_mem_wb,
    input logic irq_take,
    input logic rti,
    input logic stall,
    input logic flush
);

logic in_handler;

// Handler entry and return as seen from the strobes alone
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        in_handler <= 1'b0;
    end else if (irq_take) begin
        in_handler <= 1'b1;
    end else if (rti) begin
        in_handler <= 1'b0;
    end
end

// Nothing younger than ECALL reaches writeback
a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                               halted |-> !reg_wr_en_mem_wb)
    else $error("register write after halt");

a_no_snd_halted: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !snd)
    else $error("snd strobe while halted");

// No nesting of the handler
a_no_nested_irq: assert property (@(posedge clk) disable iff (!rst_n)
                                  irq_take |-> !in_handler)
    else $error("interrupt accepted while already in the handler");

a_no_flush_stall: assert property (@(posedge clk) disable iff (!rst_n) !(stall && flush))
    else $error("redirect during a load-use stall");

endmodule

/* dv/proc_tb.sv */
`timescale 1ns/1ps

module proc_tb;
import proc_pkg::*;

localparam int num_progs   = 6;
localparam int prog_len    = 48;
localparam int body_len    = 32;
localparam int cycle_limit = 40 * prog_len * num_progs;

// Instruction kinds of the generator
localparam int k_add   = 0;
localparam int k_sub   = 1;
localparam int k_and   = 2;
localparam int k_or    = 3;
localparam int k_xor   = 4;
localparam int k_slt   = 5;
localparam int k_addi  = 6;
localparam int k_lui   = 7;
localparam int k_lw    = 8;
localparam int k_sw    = 9;
localparam int k_beq   = 10;
localparam int k_bne   = 11;
localparam int k_jal   = 12;
localparam int k_snd   = 13;
localparam int k_ecall = 14;

logic        clk;
logic        rst_n;
logic        interrupt_key;
logic        interrupt_eth;
logic [31:0] interrupt_source_data;
logic        imem_wr_en;
logic [7:0]  imem_wr_addr;
logic [31:0] imem_wr_data;
logic        snd;
logic [31:0] interface_data;
logic        halted;

int          kind [prog_len];
logic [4:0]  rd_f [prog_len];
logic [4:0]  rs1_f [prog_len];
logic [4:0]  rs2_f [prog_len];
logic [31:0] imm_f [prog_len];
logic [31:0] model_regs [32];
logic [31:0] model_mem [64];
bit          stored [64];
logic [31:0] exp_q [$];
logic [31:0] lfsr;
logic [31:0] irq_data;
int          errors;
int          checks;
int          cycles;

proc uut (.*);

bind proc proc_props u_props (.*);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// Fibonacci LFSR on taps 32 22 2 1, stepped once per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr[0]};
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    end
    return v;
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

function automatic logic [31:0] encode(input int k, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [31:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (k == k_sub) ? 7'b0100000 : 7'b0000000;
    case (k)
        k_and:   f3 = 3'b111;
        k_or:    f3 = 3'b110;
        k_xor:   f3 = 3'b100;
        k_slt:   f3 = 3'b010;
        default: f3 = 3'b000;
    endcase
    case (k)
        k_add, k_sub, k_and, k_or, k_xor, k_slt: return {f7, rs2, rs1, f3, rd, op_rtype};
        k_addi: return {imm[11:0], rs1, 3'b000, rd, op_itype};
        k_lui:  return {imm[19:0], rd, op_lui};
        k_lw:   return {imm[11:0], 5'd0, 3'b010, rd, op_load};
        k_sw:   return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store};
        k_beq, k_bne: return {imm[12], imm[10:5], rs2, rs1, 2'b00, k == k_bne,
                              imm[4:1], imm[11], op_branch};
        k_jal:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
        k_snd:  return {12'd0, rs1, 3'd0, 5'd0, op_snd};
        default: return ecall_word;
    endcase
endfunction

// Handler is RDI x31, SND x31 and RTI
function automatic logic [31:0] handler_word(input int n);
    case (n)
        0:       return {12'd0, 5'd0, 3'd0, 5'd31, op_rdi};
        1:       return {12'd0, 5'd31, 3'd0, 5'd0, op_snd};
        default: return {25'd0, op_rti};
    endcase
endfunction

task automatic gen_program();
    logic [4:0]  last_rd;
    logic [31:0] b;
    int          pick;
    int          addr;
    last_rd = 5'd1;
    for (int a = 0; a < 64; a++) begin
        stored[a] = 1'b0;
    end
    for (int i = 0; i < prog_len; i++) begin
        rd_f[i] = 5'(take_bits(3));
        // Half of the sources read the last destination
        rs1_f[i] = take_bits(1) ? last_rd : 5'(take_bits(3));
        rs2_f[i] = take_bits(1) ? last_rd : 5'(take_bits(3));
        b = take_bits(12);
        imm_f[i] = {{20{b[11]}}, b[11:0]};
        if (i < body_len) begin
            pick = int'(take_bits(4));
            if (i < 8 && pick >= 11 && pick <= 13) pick = 6;
            if (i == 0) pick = 10;
            if (pick <= 7) kind[i] = pick;
            else if (pick <= 9) kind[i] = k_lw;
            else if (pick == 10) kind[i] = k_sw;
            else if (pick <= 13) kind[i] = pick - 1;
            else kind[i] = k_snd;
        end else if (i < body_len + 7) begin
            kind[i] = k_snd;
            rs1_f[i] = 5'(i - body_len + 1);
        end else if (i == body_len + 7) begin
            kind[i] = k_ecall;
        end else begin
            kind[i] = k_snd;
            rs1_f[i] = 5'd1;
        end
        // Loads only read words stored by the branch-free prefix
        if (kind[i] == k_lw || kind[i] == k_sw) begin
            addr = int'(take_bits(6));
            rs1_f[i] = 5'd0;
            if (kind[i] == k_lw && !stored[addr]) kind[i] = k_sw;
            if (kind[i] == k_sw && i < 8) stored[addr] = 1'b1;
            imm_f[i] = 32'(addr * 4);
        end
        if (kind[i] >= k_beq && kind[i] <= k_jal) begin
            imm_f[i] = 32'((2 + int'(take_bits(2)) % 3) * 4);
        end
        if (kind[i] == k_lui) imm_f[i] = take_bits(20);
        if (kind[i] <= k_lw || kind[i] == k_jal) last_rd = rd_f[i];
    end
endtask

task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
    if (rd != 5'd0) model_regs[rd] = v;
endtask

// Sequential ISA model without a pipeline
task automatic run_model();
    int          pc;
    int          next;
    bit          done;
    logic [31:0] a;
    logic [31:0] b;
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
    end
    exp_q.delete();
    pc = 0;
    done = 1'b0;
    while (!done) begin
        a = model_regs[rs1_f[pc]];
        b = model_regs[rs2_f[pc]];
        next = pc + 1;
        case (kind[pc])
            k_add:  set_reg(rd_f[pc], a + b);
            k_sub:  set_reg(rd_f[pc], a - b);
            k_and:  set_reg(rd_f[pc], a & b);
            k_or:   set_reg(rd_f[pc], a | b);
            k_xor:  set_reg(rd_f[pc], a ^ b);
            k_slt:  set_reg(rd_f[pc], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            k_addi: set_reg(rd_f[pc], a + imm_f[pc]);
            k_lui:  set_reg(rd_f[pc], imm_f[pc] << 12);
            k_lw:   set_reg(rd_f[pc], model_mem[imm_f[pc][7:2]]);
            k_sw:   model_mem[imm_f[pc][7:2]] = b;
            k_beq:  if (a == b) next = pc + int'(imm_f[pc] >> 2);
            k_bne:  if (a != b) next = pc + int'(imm_f[pc] >> 2);
            k_jal: begin
                set_reg(rd_f[pc], 32'((pc + 1) * 4));
                next = pc + int'(imm_f[pc] >> 2);
            end
            k_snd:  exp_q.push_back(a);
            default: done = 1'b1;
        endcase
        pc = next;
    end
endtask

// Program goes in while the core is held in reset
task automatic load_program();
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < prog_len + 3; i++) begin
        imem_wr_en = 1'b1;
        if (i < prog_len) begin
            imem_wr_addr = 8'(i);
            imem_wr_data = encode(kind[i], rd_f[i], rs1_f[i], rs2_f[i], imm_f[i]);
        end else begin
            imem_wr_addr = irq_vector[9:2] + 8'(i - prog_len);
            imem_wr_data = handler_word(i - prog_len);
        end
        @(negedge clk);
    end
    imem_wr_en = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
endtask

task automatic run_program(input bit use_irq);
    int cyc;
    int post;
    int raise_at;
    bit seen;
    cyc = 0;
    post = 0;
    seen = 1'b0;
    raise_at = 2 + int'(take_bits(2));
    // Keep watching a while after halt for stray sends
    while (post < 8) begin
        @(negedge clk);
        cyc++;
        if (snd) begin
            if (use_irq && !seen && interface_data == irq_data) begin
                seen = 1'b1;
                interrupt_key = 1'b0;
            end else if (exp_q.size() == 0) begin
                errors++;
                $display("snd strobe at %0t with no value left to send", $time);
            end else begin
                check_value(interface_data, exp_q.pop_front(), "snd value");
            end
        end
        if (use_irq && !seen && cyc == raise_at) interrupt_key = 1'b1;
        // Second source fires while the handler is still running
        interrupt_eth = use_irq && !seen && cyc >= raise_at + 2 && cyc <= raise_at + 3;
        if (post > 0) check_value(32'(halted), 32'd1, "halted dropped before reset");
        if (halted || post > 0) post++;
    end
    interrupt_key = 1'b0;
    interrupt_eth = 1'b0;
    check_value(32'(exp_q.size()), 32'd0, "values never sent");
    if (use_irq) check_value(32'(seen), 32'd1, "handler sends");
endtask

initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
        @(posedge clk);
        cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
end

initial begin
    lfsr = 32'h66c;
    errors = 0;
    checks = 0;
    rst_n = 1'b0;
    interrupt_key = 1'b0;
    interrupt_eth = 1'b0;
    interrupt_source_data = '0;
    imem_wr_en = 1'b0;
    imem_wr_addr = '0;
    imem_wr_data = '0;
    for (int p = 0; p < num_progs; p++) begin
        gen_program();
        run_model();
        irq_data = take_bits(32);
        interrupt_source_data = irq_data;
        load_program();
        run_program(p % 2 == 1);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

/* source/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [proc_pkg::xlen-1:0]       inst_fe_dec,
    input  logic [proc_pkg::xlen-1:0]       pc_fe_dec,
    input  logic                            valid_fe_dec,
    input  logic                            stall,
    input  logic                            flush,
    input  logic                            wb_en,
    input  logic [proc_pkg::reg_addr_w-1:0] wb_reg,
    input  logic [proc_pkg::xlen-1:0]       wb_data,
    output logic [proc_pkg::xlen-1:0]       rd1_dec_ex,
    output logic [proc_pkg::xlen-1:0]       rd2_dec_ex,
    output logic [proc_pkg::xlen-1:0]       imm_dec_ex,
    output logic [proc_pkg::reg_addr_w-1:0] rs1_dec_ex,
    output logic [proc_pkg::reg_addr_w-1:0] rs2_dec_ex,
    output logic [proc_pkg::reg_addr_w-1:0] rd_dec_ex,
    output proc_pkg::alu_op_t               alu_op_dec_ex,
    output logic                            alu_src_imm_dec_ex,
    output logic                            reg_wr_en_dec_ex,
    output logic                            mem_rd_en_dec_ex,
    output logic                            mem_wr_en_dec_ex,
    output proc_pkg::wb_sel_t               wb_sel_dec_ex,
    output logic                            is_branch_dec_ex,
    output logic                            branch_ne_dec_ex,
    output logic                            is_jal_dec_ex,
    output logic                            is_snd_dec_ex,
    output logic [proc_pkg::xlen-1:0]       pc_dec_ex,
    output logic [proc_pkg::reg_addr_w-1:0] rs1_if_id,
    output logic [proc_pkg::reg_addr_w-1:0] rs2_if_id,
    output logic                            rti
);
import proc_pkg::*;

logic [xlen-1:0] regs [32];
logic [xlen-1:0] rs1_val, rs2_val, imm;
logic [6:0]      opcode;
logic [2:0]      funct3;
alu_op_t         alu_op;
wb_sel_t         wb_sel;
logic            legal, alu_src_imm, reg_wr_en, mem_rd_en, mem_wr_en;
logic            is_branch, is_jal, is_snd;
logic            stop, kill;

assign opcode    = inst_fe_dec[6:0];
assign funct3    = inst_fe_dec[14:12];
assign rs1_if_id = inst_fe_dec[19:15];
assign rs2_if_id = inst_fe_dec[24:20];

// Same-cycle writeback is bypassed into the read
assign rs1_val = (rs1_if_id == '0) ? '0 :
                 (wb_en && wb_reg == rs1_if_id) ? wb_data : regs[rs1_if_id];
assign rs2_val = (rs2_if_id == '0) ? '0 :
                 (wb_en && wb_reg == rs2_if_id) ? wb_data : regs[rs2_if_id];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (wb_en && wb_reg != '0) begin
        regs[wb_reg] <= wb_data;
    end
end

always_comb begin
    legal       = 1'b1;
    alu_op      = alu_add;
    alu_src_imm = 1'b0;
    reg_wr_en   = 1'b0;
    mem_rd_en   = 1'b0;
    mem_wr_en   = 1'b0;
    wb_sel      = wb_alu;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_snd      = 1'b0;
    imm         = {{20{inst_fe_dec[31]}}, inst_fe_dec[31:20]};
    case (opcode)
        op_rtype: begin
            reg_wr_en = 1'b1;
            case (funct3)
                3'b000: alu_op = inst_fe_dec[30] ? alu_sub : alu_add;
                3'b010: alu_op = alu_slt;
                3'b100: alu_op = alu_xor;
                3'b110: alu_op = alu_or;
                3'b111: alu_op = alu_and;
                default: legal = 1'b0;
            endcase
        end
        op_itype: begin
            reg_wr_en   = 1'b1;
            alu_src_imm = 1'b1;
            legal       = (funct3 == 3'b000);
        end
        op_lui: begin
            reg_wr_en   = 1'b1;
            alu_src_imm = 1'b1;
            alu_op      = alu_passb;
            imm         = {inst_fe_dec[31:12], 12'b0};
        end
        op_load: begin
            reg_wr_en   = 1'b1;
            alu_src_imm = 1'b1;
            mem_rd_en   = 1'b1;
            wb_sel      = wb_mem;
            legal       = (funct3 == 3'b010);
        end
        op_store: begin
            alu_src_imm = 1'b1;
            mem_wr_en   = 1'b1;
            imm         = {{20{inst_fe_dec[31]}}, inst_fe_dec[31:25], inst_fe_dec[11:7]};
            legal       = (funct3 == 3'b010);
        end
        op_branch: begin
            is_branch = 1'b1;
            imm       = {{20{inst_fe_dec[31]}}, inst_fe_dec[7], inst_fe_dec[30:25],
                         inst_fe_dec[11:8], 1'b0};
            legal     = (funct3[2:1] == 2'b00);
        end
        op_jal: begin
            is_jal    = 1'b1;
            reg_wr_en = 1'b1;
            wb_sel    = wb_pc4;
            imm       = {{12{inst_fe_dec[31]}}, inst_fe_dec[19:12], inst_fe_dec[20],
                         inst_fe_dec[30:21], 1'b0};
        end
        // ECALL travels as pc4 select with no write, the halt marker
        op_system: begin
            wb_sel = wb_pc4;
            legal  = (inst_fe_dec == ecall_word);
        end
        op_rdi: begin
            reg_wr_en = 1'b1;
            wb_sel    = wb_rdi;
        end
        op_snd: is_snd = 1'b1;
        op_rti: legal = 1'b0;
        default: legal = 1'b0;
    endcase
end

// Nothing younger than an ECALL may leave decode
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) stop <= 1'b0;
    else if (valid_fe_dec && inst_fe_dec == ecall_word && !stall && !flush) stop <= 1'b1;
end

assign rti  = valid_fe_dec && opcode == op_rti && !stall && !stop;
assign kill = !valid_fe_dec || !legal || stall || flush || stop;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        reg_wr_en_dec_ex <= 1'b0;
        mem_rd_en_dec_ex <= 1'b0;
        mem_wr_en_dec_ex <= 1'b0;
        wb_sel_dec_ex    <= wb_alu;
        is_branch_dec_ex <= 1'b0;
        is_jal_dec_ex    <= 1'b0;
        is_snd_dec_ex    <= 1'b0;
    end else begin
        reg_wr_en_dec_ex <= reg_wr_en & ~kill;
        mem_rd_en_dec_ex <= mem_rd_en & ~kill;
        mem_wr_en_dec_ex <= mem_wr_en & ~kill;
        wb_sel_dec_ex    <= kill ? wb_alu : wb_sel;
        is_branch_dec_ex <= is_branch & ~kill;
        is_jal_dec_ex    <= is_jal & ~kill;
        is_snd_dec_ex    <= is_snd & ~kill;
    end
end

always_ff @(posedge clk) begin
    rd1_dec_ex         <= rs1_val;
    rd2_dec_ex         <= rs2_val;
    imm_dec_ex         <= imm;
    rs1_dec_ex         <= rs1_if_id;
    rs2_dec_ex         <= rs2_if_id;
    rd_dec_ex          <= inst_fe_dec[11:7];
    alu_op_dec_ex      <= alu_op;
    alu_src_imm_dec_ex <= alu_src_imm;
    branch_ne_dec_ex   <= funct3[0];
    pc_dec_ex          <= pc_fe_dec;
end

endmodule

/* source/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [proc_pkg::xlen-1:0]       rd1_dec_ex,
    input  logic [proc_pkg::xlen-1:0]       rd2_dec_ex,
    input  logic [proc_pkg::xlen-1:0]       imm_dec_ex,
    input  logic [proc_pkg::reg_addr_w-1:0] rd_dec_ex,
    input  proc_pkg::alu_op_t               alu_op_dec_ex,
    input  logic                            alu_src_imm_dec_ex,
    input  logic                            reg_wr_en_dec_ex,
    input  logic                            mem_rd_en_dec_ex,
    input  logic                            mem_wr_en_dec_ex,
    input  proc_pkg::wb_sel_t               wb_sel_dec_ex,
    input  logic                            is_branch_dec_ex,
    input  logic                            branch_ne_dec_ex,
    input  logic                            is_jal_dec_ex,
    input  logic                            is_snd_dec_ex,
    input  logic [proc_pkg::xlen-1:0]       pc_dec_ex,
    input  proc_pkg::fwd_sel_t              fwd_sel_a,
    input  proc_pkg::fwd_sel_t              fwd_sel_b,
    input  logic [proc_pkg::xlen-1:0]       alu_mem,
    input  logic [proc_pkg::xlen-1:0]       wb_data,
    output logic [proc_pkg::xlen-1:0]       alu_ex_mem,
    output logic [proc_pkg::xlen-1:0]       store_data_ex_mem,
    output logic [proc_pkg::reg_addr_w-1:0] rd_ex_mem,
    output logic                            reg_wr_en_ex_mem,
    output logic                            mem_rd_en_ex_mem,
    output logic                            mem_wr_en_ex_mem,
    output proc_pkg::wb_sel_t               wb_sel_ex_mem,
    output logic [proc_pkg::xlen-1:0]       pc4_ex_mem,
    output logic                            branch_taken,
    output logic [proc_pkg::xlen-1:0]       branch_target,
    output logic                            snd,
    output logic [proc_pkg::xlen-1:0]       interface_data
);
import proc_pkg::*;

logic [xlen-1:0] rs1_val, rs2_val, op_b, alu_out;

function automatic logic [xlen-1:0] pick(
    input fwd_sel_t        sel,
    input logic [xlen-1:0] reg_val,
    input logic [xlen-1:0] mem_val,
    input logic [xlen-1:0] wb_val
);
    case (sel)
        fwd_mem: return mem_val;
        fwd_wb:  return wb_val;
        default: return reg_val;
    endcase
endfunction

assign rs1_val = pick(fwd_sel_a, rd1_dec_ex, alu_mem, wb_data);
assign rs2_val = pick(fwd_sel_b, rd2_dec_ex, alu_mem, wb_data);
assign op_b    = alu_src_imm_dec_ex ? imm_dec_ex : rs2_val;

always_comb begin
    case (alu_op_dec_ex)
        alu_sub:   alu_out = rs1_val - op_b;
        alu_and:   alu_out = rs1_val & op_b;
        alu_or:    alu_out = rs1_val | op_b;
        alu_xor:   alu_out = rs1_val ^ op_b;
        alu_slt:   alu_out = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
        alu_passb: alu_out = op_b;
        default:   alu_out = rs1_val + op_b;
    endcase
end

// BNE inverts the equality test
assign branch_taken  = is_jal_dec_ex ||
                       (is_branch_dec_ex && ((rs1_val == rs2_val) ^ branch_ne_dec_ex));
assign branch_target = pc_dec_ex + imm_dec_ex;

assign snd            = is_snd_dec_ex;
assign interface_data = rs1_val;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        alu_ex_mem        <= '0;
        store_data_ex_mem <= '0;
        rd_ex_mem         <= '0;
        reg_wr_en_ex_mem  <= 1'b0;
        mem_rd_en_ex_mem  <= 1'b0;
        mem_wr_en_ex_mem  <= 1'b0;
        wb_sel_ex_mem     <= wb_alu;
        pc4_ex_mem        <= '0;
    end else begin
        alu_ex_mem        <= alu_out;
        store_data_ex_mem <= rs2_val;
        rd_ex_mem         <= rd_dec_ex;
        reg_wr_en_ex_mem  <= reg_wr_en_dec_ex;
        mem_rd_en_ex_mem  <= mem_rd_en_dec_ex;
        mem_wr_en_ex_mem  <= mem_wr_en_dec_ex;
        wb_sel_ex_mem     <= wb_sel_dec_ex;
        pc4_ex_mem        <= pc_dec_ex + 32'd4;
    end
end

endmodule

/* source/fetch.sv */
`timescale 1ns/1ps

module fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      imem_wr_en,
    input  logic [7:0]                imem_wr_addr,
    input  logic [proc_pkg::xlen-1:0] imem_wr_data,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      branch_taken,
    input  logic [proc_pkg::xlen-1:0] branch_target,
    input  logic                      rti,
    input  logic                      irq_take,
    input  logic                      halted,
    output logic [proc_pkg::xlen-1:0] inst_fe_dec,
    output logic [proc_pkg::xlen-1:0] pc_fe_dec,
    output logic                      valid_fe_dec
);
import proc_pkg::*;

logic [xlen-1:0] imem [imem_depth];
logic [xlen-1:0] pc;
logic [xlen-1:0] pc_next;
logic [xlen-1:0] ret_addr;

// Program load, done while the core sits in reset
always_ff @(posedge clk) begin
    if (imem_wr_en) begin
        imem[imem_wr_addr] <= imem_wr_data;
    end
end

// Branch beats RTI, RTI beats interrupt
always_comb begin
    if (branch_taken) pc_next = branch_target;
    else if (rti) pc_next = ret_addr;
    else if (irq_take) pc_next = irq_vector;
    else if (stall || halted) pc_next = pc;
    else pc_next = pc + 32'd4;
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pc           <= '0;
        valid_fe_dec <= 1'b0;
    end else begin
        pc <= pc_next;
        if (flush || halted) valid_fe_dec <= 1'b0;
        else if (!stall) valid_fe_dec <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        inst_fe_dec <= imem[pc[imem_aw+1:2]];
        pc_fe_dec   <= pc;
    end
    // Interrupted decode instruction resumes here
    if (irq_take) ret_addr <= pc_fe_dec;
end

endmodule

/* source/hazard.sv */
`timescale 1ns/1ps

module hazard (
    input  logic [proc_pkg::reg_addr_w-1:0] rs1_if_id,
    input  logic [proc_pkg::reg_addr_w-1:0] rs2_if_id,
    input  logic [proc_pkg::reg_addr_w-1:0] rs1_dec_ex,
    input  logic [proc_pkg::reg_addr_w-1:0] rs2_dec_ex,
    input  logic [proc_pkg::reg_addr_w-1:0] rd_dec_ex,
    input  logic                            mem_rd_en_dec_ex,
    input  logic [proc_pkg::reg_addr_w-1:0] rd_ex_mem,
    input  logic                            reg_wr_en_ex_mem,
    input  logic [proc_pkg::reg_addr_w-1:0] rd_mem_wb,
    input  logic                            reg_wr_en_mem_wb,
    output logic                            stall,
    output proc_pkg::fwd_sel_t              fwd_sel_a,
    output proc_pkg::fwd_sel_t              fwd_sel_b
);
import proc_pkg::*;

// Youngest producer wins, x0 is never forwarded
function automatic fwd_sel_t fwd_for(
    input logic [reg_addr_w-1:0] src,
    input logic [reg_addr_w-1:0] rd_mem,
    input logic                  wr_mem,
    input logic [reg_addr_w-1:0] rd_wb,
    input logic                  wr_wb
);
    if (src == '0) return fwd_none;
    if (wr_mem && rd_mem == src) return fwd_mem;
    if (wr_wb && rd_wb == src) return fwd_wb;
    return fwd_none;
endfunction

assign fwd_sel_a = fwd_for(rs1_dec_ex, rd_ex_mem, reg_wr_en_ex_mem,
                           rd_mem_wb, reg_wr_en_mem_wb);
assign fwd_sel_b = fwd_for(rs2_dec_ex, rd_ex_mem, reg_wr_en_ex_mem,
                           rd_mem_wb, reg_wr_en_mem_wb);

// Load data is not ready until memory, so hold decode for one cycle
assign stall = mem_rd_en_dec_ex && (rd_dec_ex != '0) &&
               ((rd_dec_ex == rs1_if_id) || (rd_dec_ex == rs2_if_id));

endmodule

/* source/memory.sv */
`timescale 1ns/1ps

module memory (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [proc_pkg::xlen-1:0]       alu_ex_mem,
    input  logic [proc_pkg::xlen-1:0]       store_data_ex_mem,
    input  logic [proc_pkg::reg_addr_w-1:0] rd_ex_mem,
    input  logic                            reg_wr_en_ex_mem,
    input  logic                            mem_rd_en_ex_mem,
    input  logic                            mem_wr_en_ex_mem,
    input  proc_pkg::wb_sel_t               wb_sel_ex_mem,
    input  logic [proc_pkg::xlen-1:0]       pc4_ex_mem,
    input  logic [proc_pkg::xlen-1:0]       interrupt_source_data,
    output logic                            reg_wr_en_mem_wb,
    output logic [proc_pkg::reg_addr_w-1:0] rd_mem_wb,
    output proc_pkg::wb_sel_t               wb_sel_mem_wb,
    output logic [proc_pkg::xlen-1:0]       alu_mem_wb,
    output logic [proc_pkg::xlen-1:0]       load_mem_wb,
    output logic [proc_pkg::xlen-1:0]       pc4_mem_wb
);
import proc_pkg::*;

logic [xlen-1:0]    dmem [dmem_depth];
logic [dmem_aw-1:0] word_addr;
logic [xlen-1:0]    load_data;

// Word accesses only, low address bits ignored
assign word_addr = alu_ex_mem[dmem_aw+1:2];
assign load_data = mem_rd_en_ex_mem ? dmem[word_addr] : '0;

always_ff @(posedge clk) begin
    if (mem_wr_en_ex_mem) begin
        dmem[word_addr] <= store_data_ex_mem;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        reg_wr_en_mem_wb <= 1'b0;
        wb_sel_mem_wb    <= wb_alu;
    end else begin
        reg_wr_en_mem_wb <= reg_wr_en_ex_mem;
        wb_sel_mem_wb    <= wb_sel_ex_mem;
    end
end

always_ff @(posedge clk) begin
    rd_mem_wb   <= rd_ex_mem;
    // RDI samples the device word here
    alu_mem_wb  <= (wb_sel_ex_mem == wb_rdi) ? interrupt_source_data : alu_ex_mem;
    load_mem_wb <= load_data;
    pc4_mem_wb  <= pc4_ex_mem;
end

endmodule

/* source/proc.sv */
`timescale 1ns/1ps

module proc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      interrupt_key,
    input  logic                      interrupt_eth,
    input  logic [proc_pkg::xlen-1:0] interrupt_source_data,
    input  logic                      imem_wr_en,
    input  logic [7:0]                imem_wr_addr,
    input  logic [proc_pkg::xlen-1:0] imem_wr_data,
    output logic                      snd,
    output logic [proc_pkg::xlen-1:0] interface_data,
    output logic                      halted
);
import proc_pkg::*;

// Pipeline nets are named signal_from_to
logic [xlen-1:0]       inst_fe_dec, pc_fe_dec;
logic                  valid_fe_dec;
logic [xlen-1:0]       rd1_dec_ex, rd2_dec_ex, imm_dec_ex, pc_dec_ex;
logic [reg_addr_w-1:0] rs1_dec_ex, rs2_dec_ex, rd_dec_ex, rs1_if_id, rs2_if_id;
alu_op_t               alu_op_dec_ex;
wb_sel_t               wb_sel_dec_ex, wb_sel_ex_mem, wb_sel_mem_wb;
logic                  alu_src_imm_dec_ex, reg_wr_en_dec_ex, mem_rd_en_dec_ex;
logic                  mem_wr_en_dec_ex, is_branch_dec_ex, branch_ne_dec_ex;
logic                  is_jal_dec_ex, is_snd_dec_ex;
logic [xlen-1:0]       alu_ex_mem, store_data_ex_mem, pc4_ex_mem, branch_target;
logic [reg_addr_w-1:0] rd_ex_mem, rd_mem_wb;
logic                  reg_wr_en_ex_mem, mem_rd_en_ex_mem, mem_wr_en_ex_mem;
logic                  reg_wr_en_mem_wb, branch_taken;
logic [xlen-1:0]       alu_mem_wb, load_mem_wb, pc4_mem_wb, wb_data, alu_mem;
fwd_sel_t              fwd_sel_a, fwd_sel_b;
logic                  stall, flush, rti, irq_take, irq_latch;

fetch u_fetch (.*);

decode u_decode (.*, .wb_en(reg_wr_en_mem_wb), .wb_reg(rd_mem_wb));

execute u_execute (.*);

memory u_memory (.*);

hazard u_hazard (.*);

// Value forwarded from the memory stage, by what it will write back
always_comb begin
    case (wb_sel_ex_mem)
        wb_pc4:  alu_mem = pc4_ex_mem;
        wb_rdi:  alu_mem = interrupt_source_data;
        default: alu_mem = alu_ex_mem;
    endcase
end

// RDI already carries its data in the ALU slot
always_comb begin
    case (wb_sel_mem_wb)
        wb_mem:  wb_data = load_mem_wb;
        wb_pc4:  wb_data = pc4_mem_wb;
        default: wb_data = alu_mem_wb;
    endcase
end

// Only ECALL reaches writeback selecting pc4 without a register write
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        halted <= 1'b0;
    end else if (!reg_wr_en_mem_wb && wb_sel_mem_wb == wb_pc4) begin
        halted <= 1'b1;
    end
end

// Accept only between whole instructions, with nothing else redirecting
assign irq_take = (interrupt_key | interrupt_eth) & ~irq_latch & ~branch_taken &
                  ~rti & ~stall & valid_fe_dec;
assign flush    = branch_taken | rti | irq_take;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        irq_latch <= 1'b0;
    end else if (irq_take) begin
        irq_latch <= 1'b1;
    end else if (rti && !branch_taken) begin
        irq_latch <= 1'b0;
    end
end

endmodule

/* source/proc_pkg.sv */
package proc_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int imem_depth = 256;
    localparam int dmem_depth = 256;
    localparam int imem_aw    = $clog2(imem_depth);
    localparam int dmem_aw    = $clog2(dmem_depth);

    // Handler entry, byte address
    localparam logic [xlen-1:0] irq_vector = 32'h300;

    // Standard RISC-V opcodes
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // Custom opcodes
    localparam logic [6:0] op_rti = 7'b0001000;
    localparam logic [6:0] op_rdi = 7'b0001010;
    localparam logic [6:0] op_snd = 7'b0001011;

    localparam logic [xlen-1:0] ecall_word = 32'h00000073;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_passb
    } alu_op_t;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4, wb_rdi} wb_sel_t;

    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_t;

endpackage
